//--- lbp_fixed_pkg.sv
package lbp_fixed_pkg;

	// signed Q9.16 for angles, trig results, offsets and weights
	typedef logic signed [24:0] fix_t;

	// full product of two fix_t values
	typedef logic signed [49:0] fix_prod_t;

	localparam int frac_bits = 16;

	localparam fix_t fix_one = 25'sh0010000;

	// 2*pi truncated to Q9.16
	localparam fix_t two_pi = 25'sh006487e;

endpackage

//--- lbp_image_pkg.sv
package lbp_image_pkg;

	typedef logic [7:0] pix_t;
	typedef logic [5:0] coord_t;

	// row * img_side + column
	typedef logic [11:0] addr_t;

	// floor of a neighbour offset, in pixels
	typedef logic signed [3:0] offs_t;

	typedef logic [7:0] code_t;

	localparam int n_neigh = 8;
	localparam int img_side = 64;

	// centre plus four corners per neighbour
	localparam int n_samples = 33;

endpackage

//--- lbp_ctrl.sv
`timescale 1ns/1ps

module lbp_ctrl #(
	parameter int radius = 3
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  enable,
	input  logic                  setup_done,
	input  logic                  pixel_done,
	output logic                  setup_start,
	output logic                  fetch_start,
	output lbp_image_pkg::coord_t px,
	output lbp_image_pkg::coord_t py,
	output logic                  finish
);
	import lbp_image_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_setup,
		st_fetch,
		st_busy,
		st_done
	} state_t;

	localparam coord_t first_pos = coord_t'(radius);
	localparam coord_t last_pos = coord_t'(img_side - 1 - radius);

	state_t state;
	logic last_col;
	logic last_pixel;

	assign last_col = (px == last_pos);
	assign last_pixel = last_col && (py == last_pos);
	assign fetch_start = (state == st_fetch);
	assign finish = (state == st_done);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
			setup_start <= 1'b0;
		end else begin
			setup_start <= (state == st_idle) && enable;
			case (state)
				st_idle:
					if (enable)
						state <= st_setup;
				st_setup:
					if (setup_done)
						state <= st_fetch;
				st_fetch:
					state <= st_busy;
				st_busy:
					if (pixel_done)
						state <= last_pixel ? st_done : st_fetch;
				default:
					state <= st_idle;
			endcase
		end
	end

	// raster walk over the interior, one step per written code
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			px <= first_pos;
			py <= first_pos;
		end else if (state == st_idle) begin
			px <= first_pos;
			py <= first_pos;
		end else if (state == st_busy && pixel_done && !last_pixel) begin
			if (last_col) begin
				px <= first_pos;
				py <= py + coord_t'(1);
			end else begin
				px <= px + coord_t'(1);
			end
		end
	end

	a_px_interior: assert property (@(posedge clk) disable iff (rst)
		(px >= first_pos) && (px <= last_pos))
		else $error("px left the interior");

endmodule

//--- lbp_geometry.sv
`timescale 1ns/1ps

module lbp_geometry #(
	parameter int radius = 3
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                setup_start,
	input  lbp_fixed_pkg::fix_t                 cos_data,
	input  lbp_fixed_pkg::fix_t                 sin_data,
	input  logic                                trig_valid,
	output lbp_fixed_pkg::fix_t                 theta,
	output logic                                theta_valid,
	output logic                                setup_done,
	output lbp_image_pkg::offs_t                off_x [lbp_image_pkg::n_neigh],
	output lbp_image_pkg::offs_t                off_y [lbp_image_pkg::n_neigh],
	output logic [lbp_image_pkg::n_neigh-1:0]   exact_x,
	output logic [lbp_image_pkg::n_neigh-1:0]   exact_y,
	output lbp_fixed_pkg::fix_t                 weights [lbp_image_pkg::n_neigh][4]
);
	import lbp_fixed_pkg::*;
	import lbp_image_pkg::*;

	localparam fix_t radius_fix = fix_t'(radius * fix_one);

	fix_t angle_acc;
	logic [2:0] issue_cnt;
	logic [2:0] rcv_cnt;
	logic [3:0] pending;
	logic [3:0] done_sr;
	fix_t rx [n_neigh];
	fix_t ry [n_neigh];
	fix_t tx [n_neigh];
	fix_t ty [n_neigh];

	function automatic fix_t fix_mul(fix_t a, fix_t b);
		fix_prod_t p;
		p = fix_prod_t'(a) * fix_prod_t'(b);
		return p[frac_bits +: $bits(fix_t)];
	endfunction

	// k * 2pi is exact and the divide by eight truncates
	assign theta = angle_acc >>> $clog2(n_neigh);
	assign setup_done = done_sr[3];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			theta_valid <= 1'b0;
			angle_acc <= '0;
			issue_cnt <= '0;
		end else if (setup_start) begin
			theta_valid <= 1'b1;
			angle_acc <= '0;
			issue_cnt <= '0;
		end else if (theta_valid) begin
			angle_acc <= angle_acc + two_pi;
			issue_cnt <= issue_cnt + 3'd1;
			if (issue_cnt == 3'(n_neigh - 1))
				theta_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pending <= '0;
			rcv_cnt <= '0;
			done_sr <= '0;
		end else begin
			case ({theta_valid, trig_valid})
				2'b10: pending <= pending + 4'd1;
				2'b01: pending <= pending - 4'd1;
				default: pending <= pending;
			endcase
			if (setup_start)
				rcv_cnt <= '0;
			else if (trig_valid)
				rcv_cnt <= rcv_cnt + 3'd1;
			done_sr <= {done_sr[2:0], trig_valid && (rcv_cnt == 3'(n_neigh - 1))};
		end
	end

	// results return in request order
	always_ff @(posedge clk) begin
		if (trig_valid) begin
			rx[rcv_cnt] <= fix_mul(radius_fix, cos_data);
			ry[rcv_cnt] <= fix_mul(-radius_fix, sin_data);
		end
	end

	// floor, integer flag and fractional part
	always_ff @(posedge clk) begin
		for (int n = 0; n < n_neigh; n++) begin
			off_x[n] <= rx[n][frac_bits +: $bits(offs_t)];
			off_y[n] <= ry[n][frac_bits +: $bits(offs_t)];
			exact_x[n] <= (rx[n][frac_bits-1:0] == '0);
			exact_y[n] <= (ry[n][frac_bits-1:0] == '0);
			tx[n] <= fix_t'(rx[n][frac_bits-1:0]);
			ty[n] <= fix_t'(ry[n][frac_bits-1:0]);
		end
	end

	always_ff @(posedge clk) begin
		for (int n = 0; n < n_neigh; n++) begin
			weights[n][0] <= fix_mul(fix_one - tx[n], fix_one - ty[n]);
			weights[n][1] <= fix_mul(tx[n], fix_one - ty[n]);
			weights[n][2] <= fix_mul(fix_one - tx[n], ty[n]);
			weights[n][3] <= fix_mul(tx[n], ty[n]);
		end
	end

	a_trig_requested: assert property (@(posedge clk) disable iff (rst)
		trig_valid |-> (pending != 4'd0))
		else $error("trig result without an outstanding angle");

endmodule

//--- lbp_fetch.sv
`timescale 1ns/1ps

module lbp_fetch (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                fetch_start,
	input  lbp_image_pkg::coord_t               px,
	input  lbp_image_pkg::coord_t               py,
	input  lbp_image_pkg::offs_t                off_x [lbp_image_pkg::n_neigh],
	input  lbp_image_pkg::offs_t                off_y [lbp_image_pkg::n_neigh],
	input  logic [lbp_image_pkg::n_neigh-1:0]   exact_x,
	input  logic [lbp_image_pkg::n_neigh-1:0]   exact_y,
	input  lbp_image_pkg::pix_t                 gray_data,
	output lbp_image_pkg::addr_t                gray_addr,
	output logic                                gray_oe,
	output lbp_image_pkg::pix_t                 center,
	output lbp_image_pkg::pix_t                 samples [lbp_image_pkg::n_samples-1],
	output logic                                window_valid
);
	import lbp_image_pkg::*;

	logic reading;
	logic [5:0] rd_cnt;
	logic [5:0] cur_idx;
	logic oe_d;
	logic [5:0] idx_d;

	// centre is read in the fetch_start cycle itself
	assign cur_idx = fetch_start ? 6'd0 : rd_cnt;
	assign gray_oe = fetch_start || reading;

	always_comb begin
		logic [5:0] k;
		logic [2:0] nb;
		offs_t dx;
		offs_t dy;
		coord_t sx;
		coord_t sy;
		k = cur_idx - 6'd1;
		nb = k[4:2];
		dx = off_x[nb];
		dy = off_y[nb];
		// corner bit 1 picks x2, bit 0 picks y2
		if (k[1] && !exact_x[nb])
			dx = dx + 4'sd1;
		if (k[0] && !exact_y[nb])
			dy = dy + 4'sd1;
		sx = (cur_idx == 6'd0) ? px : px + coord_t'(dx);
		sy = (cur_idx == 6'd0) ? py : py + coord_t'(dy);
		gray_addr = addr_t'(sy) * addr_t'(img_side) + addr_t'(sx);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			reading <= 1'b0;
			rd_cnt <= '0;
			oe_d <= 1'b0;
			idx_d <= '0;
			window_valid <= 1'b0;
		end else begin
			if (fetch_start) begin
				reading <= 1'b1;
				rd_cnt <= 6'd1;
			end else if (reading) begin
				rd_cnt <= rd_cnt + 6'd1;
				if (rd_cnt == 6'(n_samples - 1))
					reading <= 1'b0;
			end
			oe_d <= gray_oe;
			idx_d <= cur_idx;
			window_valid <= oe_d && (idx_d == 6'(n_samples - 1));
		end
	end

	always_ff @(posedge clk) begin
		if (oe_d) begin
			if (idx_d == 6'd0)
				center <= gray_data;
			else
				samples[5'(idx_d - 6'd1)] <= gray_data;
		end
	end

endmodule

//--- lbp_interp.sv
`timescale 1ns/1ps

module lbp_interp (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 window_valid,
	input  lbp_image_pkg::pix_t  samples [lbp_image_pkg::n_samples-1],
	input  lbp_fixed_pkg::fix_t  weights [lbp_image_pkg::n_neigh][4],
	output lbp_image_pkg::pix_t  neigh_val [lbp_image_pkg::n_neigh],
	output logic                 interp_valid
);
	import lbp_fixed_pkg::*;
	import lbp_image_pkg::*;

	fix_prod_t term [n_neigh][4];
	logic stage1_valid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stage1_valid <= 1'b0;
			interp_valid <= 1'b0;
		end else begin
			stage1_valid <= window_valid;
			interp_valid <= stage1_valid;
		end
	end

	// corner times weight with 16 fraction bits
	// swap the corner bits to pair each weight with its sample
	always_ff @(posedge clk) begin
		if (window_valid) begin
			for (int n = 0; n < n_neigh; n++) begin
				for (int c = 0; c < 4; c++) begin
					term[n][c] <= fix_prod_t'(weights[n][c]) *
						fix_prod_t'({1'b0, samples[4*n + 2*(c % 2) + c / 2]});
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		fix_prod_t sum;
		if (stage1_valid) begin
			for (int n = 0; n < n_neigh; n++) begin
				sum = term[n][0] + term[n][1] + term[n][2] + term[n][3];
				// round half up on the first dropped bit
				neigh_val[n] <= sum[frac_bits +: $bits(pix_t)] + pix_t'(sum[frac_bits-1]);
			end
		end
	end

endmodule

//--- lbp_threshold.sv
`timescale 1ns/1ps

module lbp_threshold (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  interp_valid,
	input  lbp_image_pkg::pix_t   neigh_val [lbp_image_pkg::n_neigh],
	input  lbp_image_pkg::pix_t   center,
	input  lbp_image_pkg::coord_t px,
	input  lbp_image_pkg::coord_t py,
	output lbp_image_pkg::addr_t  lbp_addr,
	output lbp_image_pkg::code_t  lbp_data,
	output logic                  lbp_wen,
	output logic                  pixel_done
);
	import lbp_image_pkg::*;

	code_t code;

	always_comb begin
		for (int k = 0; k < n_neigh; k++)
			code[k] = (neigh_val[k] >= center);
	end

	assign pixel_done = lbp_wen;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			lbp_wen <= 1'b0;
		else
			lbp_wen <= interp_valid;
	end

	always_ff @(posedge clk) begin
		if (interp_valid) begin
			lbp_data <= code;
			lbp_addr <= addr_t'(py) * addr_t'(img_side) + addr_t'(px);
		end
	end

	// one write per pixel and never back to back
	a_wen_single: assert property (@(posedge clk) disable iff (rst)
		lbp_wen |=> !lbp_wen)
		else $error("lbp_wen high on consecutive cycles");

endmodule

//--- clbp.sv
`timescale 1ns/1ps

module clbp #(
	parameter int radius = 3
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 enable,
	input  lbp_image_pkg::pix_t  gray_data,
	input  lbp_fixed_pkg::fix_t  cos_data,
	input  lbp_fixed_pkg::fix_t  sin_data,
	input  logic                 trig_valid,
	output lbp_image_pkg::addr_t gray_addr,
	output logic                 gray_oe,
	output lbp_image_pkg::addr_t lbp_addr,
	output logic                 lbp_wen,
	output lbp_image_pkg::code_t lbp_data,
	output lbp_fixed_pkg::fix_t  theta,
	output logic                 theta_valid,
	output logic                 finish
);
	import lbp_fixed_pkg::*;
	import lbp_image_pkg::*;

	logic setup_start;
	logic setup_done;
	logic fetch_start;
	logic window_valid;
	logic interp_valid;
	logic pixel_done;
	coord_t px;
	coord_t py;
	offs_t off_x [n_neigh];
	offs_t off_y [n_neigh];
	logic [n_neigh-1:0] exact_x;
	logic [n_neigh-1:0] exact_y;
	fix_t weights [n_neigh][4];
	pix_t center;
	pix_t samples [n_samples-1];
	pix_t neigh_val [n_neigh];

	lbp_ctrl #(
		.radius(radius)
	) u_ctrl (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.setup_done(setup_done),
		.pixel_done(pixel_done),
		.setup_start(setup_start),
		.fetch_start(fetch_start),
		.px(px),
		.py(py),
		.finish(finish)
	);

	lbp_geometry #(
		.radius(radius)
	) u_geometry (
		.clk(clk),
		.rst(rst),
		.setup_start(setup_start),
		.cos_data(cos_data),
		.sin_data(sin_data),
		.trig_valid(trig_valid),
		.theta(theta),
		.theta_valid(theta_valid),
		.setup_done(setup_done),
		.off_x(off_x),
		.off_y(off_y),
		.exact_x(exact_x),
		.exact_y(exact_y),
		.weights(weights)
	);

	lbp_fetch u_fetch (
		.clk(clk),
		.rst(rst),
		.fetch_start(fetch_start),
		.px(px),
		.py(py),
		.off_x(off_x),
		.off_y(off_y),
		.exact_x(exact_x),
		.exact_y(exact_y),
		.gray_data(gray_data),
		.gray_addr(gray_addr),
		.gray_oe(gray_oe),
		.center(center),
		.samples(samples),
		.window_valid(window_valid)
	);

	lbp_interp u_interp (
		.clk(clk),
		.rst(rst),
		.window_valid(window_valid),
		.samples(samples),
		.weights(weights),
		.neigh_val(neigh_val),
		.interp_valid(interp_valid)
	);

	lbp_threshold u_threshold (
		.clk(clk),
		.rst(rst),
		.interp_valid(interp_valid),
		.neigh_val(neigh_val),
		.center(center),
		.px(px),
		.py(py),
		.lbp_addr(lbp_addr),
		.lbp_data(lbp_data),
		.lbp_wen(lbp_wen),
		.pixel_done(pixel_done)
	);

endmodule

//--- tb_clbp.sv
`timescale 1ns/1ps

module tb_clbp;
	import lbp_fixed_pkg::*;
	import lbp_image_pkg::*;

	localparam int radius = 3;
	localparam int n_side = img_side - 2 * radius;
	localparam int run_timeout = 200000;

	logic clk;
	logic rst;
	logic enable;
	pix_t gray_data;
	fix_t cos_data;
	fix_t sin_data;
	logic trig_valid;
	addr_t gray_addr;
	logic gray_oe;
	addr_t lbp_addr;
	logic lbp_wen;
	code_t lbp_data;
	fix_t theta;
	logic theta_valid;
	logic finish;

	pix_t image [img_side * img_side];
	int seed = 32'h703a;
	int theta_q [$];
	longint due_q [$];
	addr_t rd_list [$];
	logic enabled_once;
	logic run_over;
	code_t exp_code;
	int theta_count;
	int write_count;
	int exp_x;
	int exp_y;

	clbp #(
		.radius(radius)
	) uut (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.gray_data(gray_data),
		.cos_data(cos_data),
		.sin_data(sin_data),
		.trig_valid(trig_valid),
		.gray_addr(gray_addr),
		.gray_oe(gray_oe),
		.lbp_addr(lbp_addr),
		.lbp_wen(lbp_wen),
		.lbp_data(lbp_data),
		.theta(theta),
		.theta_valid(theta_valid),
		.finish(finish)
	);

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic mismatch(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	task automatic timed_out(input string msg);
		$display("timeout: %s", msg);
		abort_run();
	endtask

	// k * 2pi / 8 with 2pi truncated to 16 fraction bits
	function automatic int expected_theta(input int k);
		int two_pi_q;
		two_pi_q = $rtoi(6.283185307179586 * 65536.0);
		return (k * two_pi_q) / n_neigh;
	endfunction

	function automatic bit in_window(input addr_t rd, input addr_t wr);
		int dr;
		int dc;
		dr = int'(rd) / img_side - int'(wr) / img_side;
		dc = int'(rd) % img_side - int'(wr) % img_side;
		return (dr >= -(radius + 1)) && (dr <= radius + 1) &&
			(dc >= -(radius + 1)) && (dc <= radius + 1);
	endfunction

	// 0 gives a flat image, 1 a horizontal ramp
	task automatic fill_image(input int pattern);
		for (int a = 0; a < img_side * img_side; a++)
			image[a] = (pattern == 0) ? pix_t'(137) : pix_t'(4 * (a % img_side));
	endtask

	task automatic run_image(input int pattern, input code_t code);
		int wait_cnt;
		fill_image(pattern);
		exp_code = code;
		theta_count = 0;
		write_count = 0;
		exp_x = radius;
		exp_y = radius;
		run_over = 1'b0;
		rd_list.delete();
		@(posedge clk);
		#2;
		enable = 1'b1;
		enabled_once = 1'b1;
		@(posedge clk);
		#2;
		enable = 1'b0;
		wait_cnt = 0;
		while (!run_over) begin
			if (wait_cnt == run_timeout)
				timed_out("finish did not arrive");
			@(posedge clk);
			#2;
			wait_cnt++;
		end
		// stray writes after finish are caught by the output checks
		repeat (20) @(posedge clk);
		#2;
		assert (theta_count == n_neigh)
			else mismatch($sformatf("%0d theta strobes, expected 8", theta_count));
		assert (write_count == n_side * n_side)
			else mismatch($sformatf("%0d writes in the run", write_count));
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// image memory and trig unit
	initial begin : bus_models
		pix_t gray_next;
		logic rd_pending;
		addr_t rd_addr;
		logic trig_now;
		int theta_now;
		longint cyc;
		longint due;
		longint last_due;
		int lat;
		real ang;
		gray_next = '0;
		rd_pending = 1'b0;
		rd_addr = '0;
		theta_now = 0;
		cyc = 0;
		last_due = 0;
		forever begin
			@(posedge clk);
			#1;
			cyc++;
			if (rd_pending)
				gray_next = image[rd_addr];
			rd_pending = gray_oe;
			rd_addr = gray_addr;
			trig_now = 1'b0;
			if (due_q.size() > 0 && due_q[0] <= cyc) begin
				trig_now = 1'b1;
				theta_now = theta_q.pop_front();
				due = due_q.pop_front();
			end
			// results stay in request order
			if (theta_valid) begin
				lat = 1 + int'($unsigned($random(seed)) % 4);
				due = cyc + lat;
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				due_q.push_back(due);
				theta_q.push_back(int'(theta));
			end
			#1;
			gray_data = gray_next;
			trig_valid = trig_now;
			if (trig_now) begin
				ang = real'(theta_now) / 65536.0;
				cos_data = fix_t'(int'($cos(ang) * 65536.0));
				sin_data = fix_t'(int'($sin(ang) * 65536.0));
			end
		end
	end

	initial begin : output_checks
		forever begin
			@(posedge clk);
			#1;
			if (theta_valid) begin
				assert (theta_count < n_neigh)
					else mismatch("more than eight theta strobes");
				assert (int'(theta) == expected_theta(theta_count))
					else mismatch($sformatf("theta %0d is %0d, expected %0d", theta_count,
						int'(theta), expected_theta(theta_count)));
				theta_count++;
			end
			if (gray_oe)
				rd_list.push_back(gray_addr);
			if (lbp_wen) begin
				assert (!run_over)
					else mismatch("result write after finish");
				assert (int'(lbp_addr) == exp_y * img_side + exp_x)
					else mismatch($sformatf("write address %0d, expected %0d", lbp_addr,
						exp_y * img_side + exp_x));
				assert (lbp_data == exp_code)
					else mismatch($sformatf("code %h at %0d, expected %h", lbp_data,
						lbp_addr, exp_code));
				foreach (rd_list[i])
					assert (in_window(rd_list[i], lbp_addr))
						else mismatch($sformatf("read %0d outside window of %0d",
							rd_list[i], lbp_addr));
				rd_list.delete();
				write_count++;
				if (exp_x == img_side - 1 - radius) begin
					exp_x = radius;
					exp_y++;
				end else begin
					exp_x++;
				end
			end
			if (finish) begin
				assert (write_count == n_side * n_side)
					else mismatch($sformatf("finish after %0d writes", write_count));
				run_over = 1'b1;
			end
		end
	end

	a_quiet_before_enable: assert property (@(posedge clk) disable iff (rst)
		!enabled_once |-> !(theta_valid || gray_oe || lbp_wen || finish))
		else mismatch("DUT output active before enable");

	a_finish_single: assert property (@(posedge clk) disable iff (rst)
		finish |=> !finish)
		else mismatch("finish high for more than one cycle");

	a_finish_after_write: assert property (@(posedge clk) disable iff (rst)
		finish |-> $past(lbp_wen))
		else mismatch("finish not in the cycle after the last write");

	initial begin
		rst = 1'b1;
		enable = 1'b0;
		gray_data = '0;
		cos_data = '0;
		sin_data = '0;
		trig_valid = 1'b0;
		enabled_once = 1'b0;
		run_over = 1'b0;
		exp_code = '0;
		theta_count = 0;
		write_count = 0;
		exp_x = radius;
		exp_y = radius;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		// idle stretch before the first enable
		repeat (10) @(posedge clk);
		run_image(0, 8'hff);
		run_image(1, 8'hc7);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- sim.f
lbp_fixed_pkg.sv
lbp_image_pkg.sv
lbp_ctrl.sv
lbp_geometry.sv
lbp_fetch.sv
lbp_interp.sv
lbp_threshold.sv
clbp.sv
tb_clbp.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the clbp testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_clbp \
	-f sim.f -o vsim_clbp; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/vsim_clbp > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
	exit 0
fi
exit 1
